// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic                      clock,
    input  logic                      rst_n,
    input  dp_pkg::opcode_t           op,
    input  logic [dp_pkg::DST_W-1:0]  d,
    input  dp_pkg::word_t             a,
    input  dp_pkg::word_t             b,
    output dp_pkg::alu_out_t          result
);
    import dp_pkg::*;

    word_t              r_next;
    opcode_t            op_q;
    logic [DST_W-1:0]   d_q;
    word_t              r_q;

    always_comb begin
        case (op)
            OP_ADD:    r_next = a + b;  // Wraps at 16 bits
            OP_SUB:    r_next = a - b;
            OP_AND:    r_next = a & b;
            OP_OR:     r_next = a | b;
            OP_XOR:    r_next = a ^ b;
            OP_PASS_A: r_next = a;
            default:   r_next = '0;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            op_q <= OP_NOP;
        end else begin
            op_q <= op;
        end
    end

    always_ff @(posedge clock) begin
        d_q <= d;
        r_q <= r_next;
    end

    assign result = '{op: op_q, d: d_q, r: r_q};

endmodule

// ==== hdl/dp_pkg.sv ====
package dp_pkg;

    localparam int WORD_W = 16;
    localparam int SRC_W  = 4;          // 16 locations per bank
    localparam int DST_W  = SRC_W + 1;  // Top bit selects bank B

    typedef logic [WORD_W-1:0] word_t;

    typedef enum logic [3:0] {
        OP_NOP    = 4'd0,  // No write
        OP_ADD    = 4'd1,
        OP_SUB    = 4'd2,
        OP_AND    = 4'd3,
        OP_OR     = 4'd4,
        OP_XOR    = 4'd5,
        OP_PASS_A = 4'd6
    } opcode_t;

    // All zero is a NOP
    typedef struct packed {
        opcode_t            op;
        logic [DST_W-1:0]   d;
        logic [SRC_W-1:0]   a;
        logic [SRC_W-1:0]   b;
    } instr_t;

    // What the ALU stage presents to write-back
    typedef struct packed {
        opcode_t            op;
        logic [DST_W-1:0]   d;
        word_t              r;
    } alu_out_t;

    // One memory write request
    typedef struct packed {
        logic               wren;
        logic [SRC_W-1:0]   addr;
        word_t              data;
    } bank_wr_t;

endpackage

// ==== hdl/dp_top.sv ====
`timescale 1ns/1ps

module dp_top #(
    parameter int IO_PORT_ADDR = 15
) (
    input  logic                  clock,
    input  logic                  rst_n,

    input  dp_pkg::instr_t        instr,

    input  logic                  a_io_in_empty,
    output logic                  a_io_rden,
    input  dp_pkg::word_t         a_io_in,
    input  logic                  a_io_out_full,
    output logic                  a_io_wren,
    output dp_pkg::word_t         a_io_out,

    input  logic                  b_io_in_empty,
    output logic                  b_io_rden,
    input  dp_pkg::word_t         b_io_in,
    input  logic                  b_io_out_full,
    output logic                  b_io_wren,
    output dp_pkg::word_t         b_io_out,

    output logic                  io_ready,
    output dp_pkg::alu_out_t      alu_result
);
    import dp_pkg::*;

    opcode_t            iss_op;
    logic [DST_W-1:0]   iss_d;
    word_t              a_operand;
    word_t              b_operand;
    bank_wr_t           a_wr;
    bank_wr_t           b_wr;

    issue_stage #(
        .IO_PORT_ADDR   (IO_PORT_ADDR)
    ) issue (
        .clock          (clock),
        .rst_n          (rst_n),
        .instr          (instr),
        .a_io_in_empty  (a_io_in_empty),
        .b_io_in_empty  (b_io_in_empty),
        .a_io_out_full  (a_io_out_full),
        .b_io_out_full  (b_io_out_full),
        .io_ready       (io_ready),
        .a_io_rden      (a_io_rden),
        .b_io_rden      (b_io_rden),
        .op             (iss_op),
        .d              (iss_d)
    );

    // Banks read straight from the instruction
    operand_bank #(
        .IO_PORT_ADDR   (IO_PORT_ADDR)
    ) bank_a (
        .clock          (clock),
        .raddr          (instr.a),
        .io_in          (a_io_in),
        .wr             (a_wr),
        .operand        (a_operand)
    );

    operand_bank #(
        .IO_PORT_ADDR   (IO_PORT_ADDR)
    ) bank_b (
        .clock          (clock),
        .raddr          (instr.b),
        .io_in          (b_io_in),
        .wr             (b_wr),
        .operand        (b_operand)
    );

    alu alu0 (
        .clock          (clock),
        .rst_n          (rst_n),
        .op             (iss_op),
        .d              (iss_d),
        .a              (a_operand),
        .b              (b_operand),
        .result         (alu_result)
    );

    write_back #(
        .IO_PORT_ADDR   (IO_PORT_ADDR)
    ) wb (
        .result         (alu_result),
        .a_wr           (a_wr),
        .b_wr           (b_wr),
        .a_io_wren      (a_io_wren),
        .b_io_wren      (b_io_wren),
        .a_io_out       (a_io_out),
        .b_io_out       (b_io_out)
    );

endmodule

// ==== hdl/issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage #(
    parameter int IO_PORT_ADDR = 15
) (
    input  logic                      clock,
    input  logic                      rst_n,
    input  dp_pkg::instr_t            instr,
    input  logic                      a_io_in_empty,
    input  logic                      b_io_in_empty,
    input  logic                      a_io_out_full,
    input  logic                      b_io_out_full,
    output logic                      io_ready,
    output logic                      a_io_rden,
    output logic                      b_io_rden,
    output dp_pkg::opcode_t           op,
    output logic [dp_pkg::DST_W-1:0]  d
);
    import dp_pkg::*;

    localparam logic [SRC_W-1:0] PORT_ADDR = SRC_W'(IO_PORT_ADDR);

    logic               a_reads_port;
    logic               b_reads_port;
    logic               writes_port;
    logic               out_full;
    opcode_t            kept_op;
    logic [DST_W-1:0]   kept_d;

    // Port reads count whatever the opcode
    assign a_reads_port = (instr.a == PORT_ADDR);
    assign b_reads_port = (instr.b == PORT_ADDR);

    assign writes_port = (instr.op != OP_NOP) && (instr.d[SRC_W-1:0] == PORT_ADDR);
    assign out_full    = instr.d[DST_W-1] ? b_io_out_full : a_io_out_full;

    assign io_ready = !(a_reads_port && a_io_in_empty)
                   && !(b_reads_port && b_io_in_empty)
                   && !(writes_port && out_full);

    // A stalled read gets no strobe
    assign a_io_rden = io_ready && a_reads_port;
    assign b_io_rden = io_ready && b_reads_port;

    // Annul to NOP
    assign kept_op = io_ready ? instr.op : OP_NOP;
    assign kept_d  = io_ready ? instr.d : '0;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            op <= OP_NOP;
        end else begin
            op <= kept_op;
        end
    end

    always_ff @(posedge clock) begin
        d <= kept_d;  // Meaningless under a NOP
    end

endmodule

// ==== hdl/operand_bank.sv ====
`timescale 1ns/1ps

module operand_bank #(
    parameter int IO_PORT_ADDR = 15
) (
    input  logic                      clock,
    input  logic [dp_pkg::SRC_W-1:0]  raddr,
    input  dp_pkg::word_t             io_in,
    input  dp_pkg::bank_wr_t          wr,
    output dp_pkg::word_t             operand
);
    import dp_pkg::*;

    localparam int               DEPTH     = 2 ** SRC_W;
    localparam logic [SRC_W-1:0] PORT_ADDR = SRC_W'(IO_PORT_ADDR);

    word_t mem [0:DEPTH-1];

    // Write from the write-back stage
    always_ff @(posedge clock) begin
        if (wr.wren) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Same-cycle read of a written word gives the old value
    always_ff @(posedge clock) begin
        if (raddr == PORT_ADDR) begin
            operand <= io_in;  // Show-ahead port data
        end else begin
            operand <= mem[raddr];
        end
    end

endmodule

// ==== hdl/write_back.sv ====
`timescale 1ns/1ps

module write_back #(
    parameter int IO_PORT_ADDR = 15
) (
    input  dp_pkg::alu_out_t  result,
    output dp_pkg::bank_wr_t  a_wr,
    output dp_pkg::bank_wr_t  b_wr,
    output logic              a_io_wren,
    output logic              b_io_wren,
    output dp_pkg::word_t     a_io_out,
    output dp_pkg::word_t     b_io_out
);
    import dp_pkg::*;

    localparam logic [SRC_W-1:0] PORT_ADDR = SRC_W'(IO_PORT_ADDR);

    logic               active;
    logic               to_b;
    logic               at_port;
    logic [SRC_W-1:0]   addr;

    assign active  = (result.op != OP_NOP);
    assign to_b    = result.d[DST_W-1];
    assign addr    = result.d[SRC_W-1:0];
    assign at_port = (addr == PORT_ADDR);

    // Memory side never sees the port address
    always_comb begin
        a_wr.wren = active && !to_b && !at_port;
        a_wr.addr = addr;
        a_wr.data = result.r;
        b_wr.wren = active && to_b && !at_port;
        b_wr.addr = addr;
        b_wr.data = result.r;
    end

    // Write-port pushes
    assign a_io_wren = active && !to_b && at_port;
    assign b_io_wren = active && to_b && at_port;
    assign a_io_out  = result.r;
    assign b_io_out  = result.r;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

if ! verilator --binary --timing --top-module tb_dp_top -f sources.f; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_dp_top 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qxF 'All tests passed!' <<< "$output"; then
    exit 0
else
    echo "Pass line not found in simulation output"
    exit 1
fi

// ==== sources.f ====
hdl/dp_pkg.sv
hdl/issue_stage.sv
hdl/operand_bank.sv
hdl/alu.sv
hdl/write_back.sv
hdl/dp_top.sv
tb/tb_dp_top.sv

// ==== tb/tb_dp_top.sv ====
`timescale 1ns/1ps

module tb_dp_top;
    import dp_pkg::*;

    localparam logic [SRC_W-1:0] PORT = SRC_W'(15);  // Default IO_PORT_ADDR

    localparam int RESET_CYCLES = 3;
    localparam int T_RESET      = 1;
    localparam int T_LOAD       = 51;  // 17 instructions of 3 cycles
    localparam int T_ALU        = 18;
    localparam int T_ROUTE      = 21;
    localparam int T_STALL      = 30;
    localparam int T_PIPE       = 5;
    localparam int MAX_CYCLES   = 2 * (RESET_CYCLES + T_RESET + T_LOAD + T_ALU + T_ROUTE
                                       + T_STALL + T_PIPE) + 100;

    logic       clock;
    logic       rst_n;
    instr_t     instr;
    logic       a_io_in_empty;
    logic       b_io_in_empty;
    logic       a_io_out_full;
    logic       b_io_out_full;
    word_t      a_io_in;
    word_t      b_io_in;
    logic       a_io_rden;
    logic       b_io_rden;
    logic       a_io_wren;
    logic       b_io_wren;
    word_t      a_io_out;
    word_t      b_io_out;
    logic       io_ready;
    alu_out_t   alu_result;

    logic [31:0] lfsr_state;
    int          cycle_count = 0;

    // Expected memory contents
    word_t mem_a [0:15];
    word_t mem_b [0:15];

    dp_top dut0 (
        .clock          (clock),
        .rst_n          (rst_n),
        .instr          (instr),
        .a_io_in_empty  (a_io_in_empty),
        .a_io_rden      (a_io_rden),
        .a_io_in        (a_io_in),
        .a_io_out_full  (a_io_out_full),
        .a_io_wren      (a_io_wren),
        .a_io_out       (a_io_out),
        .b_io_in_empty  (b_io_in_empty),
        .b_io_rden      (b_io_rden),
        .b_io_in        (b_io_in),
        .b_io_out_full  (b_io_out_full),
        .b_io_wren      (b_io_wren),
        .b_io_out       (b_io_out),
        .io_ready       (io_ready),
        .alu_result     (alu_result)
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $fatal(1);
        end
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    // Galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] bits;
        int          k;
        bits = '0;
        for (k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    function automatic word_t expected_result(input opcode_t op, input word_t a, input word_t b);
        logic [WORD_W:0] sum;
        word_t           r;
        int              k;
        r = '0;
        if (op == OP_ADD) begin
            sum = {1'b0, a} + {1'b0, b};
            r   = sum[WORD_W-1:0];  // Carry dropped
        end else if (op == OP_SUB) begin
            sum = {1'b0, a} + {1'b0, ~b} + (WORD_W+1)'(1);  // Two's complement
            r   = sum[WORD_W-1:0];
        end else if (op == OP_PASS_A) begin
            r = a;
        end else begin
            for (k = 0; k < WORD_W; k++) begin
                case (op)
                    OP_AND:  r[k] = a[k] && b[k];
                    OP_OR:   r[k] = a[k] || b[k];
                    OP_XOR:  r[k] = a[k] != b[k];
                    default: r[k] = 1'b0;
                endcase
            end
        end
        return r;
    endfunction

    function automatic instr_t make_instr(input opcode_t op, input logic to_b,
                                          input logic [SRC_W-1:0] dst,
                                          input logic [SRC_W-1:0] a,
                                          input logic [SRC_W-1:0] b);
        instr_t i;
        i.op = op;
        i.d  = {to_b, dst};
        i.a  = a;
        i.b  = b;
        return i;
    endfunction

    // Issues one instruction and checks its result two cycles later
    task automatic run_instr(input instr_t i, input word_t a_port, input word_t b_port);
        word_t a_val;
        word_t b_val;
        word_t exp_r;
        logic  port_wr;
        a_val   = (i.a == PORT) ? a_port : mem_a[i.a];
        b_val   = (i.b == PORT) ? b_port : mem_b[i.b];
        exp_r   = expected_result(i.op, a_val, b_val);
        port_wr = (i.op != OP_NOP) && (i.d[SRC_W-1:0] == PORT);

        @(negedge clock);
        instr   = i;
        a_io_in = a_port;
        b_io_in = b_port;
        #1;
        check("io_ready at issue", 32'(io_ready), 32'd1);
        check("a_io_rden at issue", 32'(a_io_rden), 32'(i.a == PORT));
        check("b_io_rden at issue", 32'(b_io_rden), 32'(i.b == PORT));
        check("a_io_wren idle", 32'(a_io_wren), 32'd0);
        check("b_io_wren idle", 32'(b_io_wren), 32'd0);

        @(negedge clock);
        instr = '0;
        #1;
        check("a_io_rden after issue", 32'(a_io_rden), 32'd0);
        check("b_io_rden after issue", 32'(b_io_rden), 32'd0);
        check("alu_result op in flight", 32'(alu_result.op), 32'(OP_NOP));

        @(negedge clock);
        check("alu_result op", 32'(alu_result.op), 32'(i.op));
        check("alu_result d", 32'(alu_result.d), 32'(i.d));
        check("alu_result r", 32'(alu_result.r), 32'(exp_r));
        check("a_io_wren", 32'(a_io_wren), 32'(port_wr && !i.d[DST_W-1]));
        check("b_io_wren", 32'(b_io_wren), 32'(port_wr && i.d[DST_W-1]));
        if (port_wr) begin
            check("I/O write data", 32'(i.d[DST_W-1] ? b_io_out : a_io_out), 32'(exp_r));
        end else if (i.op != OP_NOP) begin
            if (i.d[DST_W-1]) begin
                mem_b[i.d[SRC_W-1:0]] = exp_r;
            end else begin
                mem_a[i.d[SRC_W-1:0]] = exp_r;
            end
        end
    endtask

    task automatic expect_stall(input instr_t i);
        @(negedge clock);
        instr = i;
        #1;
        check("io_ready on stall", 32'(io_ready), 32'd0);
        check("a_io_rden on stall", 32'(a_io_rden), 32'd0);
        check("b_io_rden on stall", 32'(b_io_rden), 32'd0);
        @(negedge clock);
        instr = '0;
        @(negedge clock);
        check("annulled op", 32'(alu_result.op), 32'(OP_NOP));
        check("a_io_wren on annul", 32'(a_io_wren), 32'd0);
        check("b_io_wren on annul", 32'(b_io_wren), 32'd0);
    endtask

    task automatic check_reset_state();
        @(negedge clock);
        #1;
        check("io_ready after reset", 32'(io_ready), 32'd1);
        check("a_io_rden after reset", 32'(a_io_rden), 32'd0);
        check("b_io_rden after reset", 32'(b_io_rden), 32'd0);
        check("a_io_wren after reset", 32'(a_io_wren), 32'd0);
        check("b_io_wren after reset", 32'(b_io_wren), 32'd0);
        check("alu_result op after reset", 32'(alu_result.op), 32'(OP_NOP));
    endtask

    task automatic load_from_ports();
        int k;
        for (k = 0; k < 4; k++) begin
            run_instr(make_instr(OP_PASS_A, 1'b0, SRC_W'(k), PORT, 4'd0),
                      word_t'(rand_bits(WORD_W)), '0);
        end
        run_instr(make_instr(OP_PASS_A, 1'b0, 4'd4, PORT, 4'd0), '0, '0);  // A4 holds zero
        // B port data ORed with the zero word
        for (k = 0; k < 4; k++) begin
            run_instr(make_instr(OP_OR, 1'b1, SRC_W'(k), 4'd4, PORT),
                      '0, word_t'(rand_bits(WORD_W)));
        end
        // Read back through the write ports so memory stays as loaded
        for (k = 0; k < 4; k++) begin
            run_instr(make_instr(OP_PASS_A, 1'b0, PORT, SRC_W'(k), 4'd0), '0, '0);
        end
        for (k = 0; k < 4; k++) begin
            run_instr(make_instr(OP_XOR, 1'b1, PORT, 4'd4, SRC_W'(k)), '0, '0);
        end
    endtask

    task automatic alu_opcodes();
        opcode_t ops [6];
        int      k;
        ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_PASS_A};
        for (k = 0; k < 6; k++) begin
            run_instr(make_instr(ops[k], 1'b0, 4'd10, SRC_W'(rand_bits(2)),
                                 SRC_W'(rand_bits(2))), '0, '0);
        end
    endtask

    task automatic write_back_routing();
        run_instr(make_instr(OP_ADD, 1'b1, 4'd5, 4'd0, 4'd1), '0, '0);
        run_instr(make_instr(OP_XOR, 1'b0, 4'd11, 4'd4, 4'd5), '0, '0);
        run_instr(make_instr(OP_SUB, 1'b0, 4'd6, 4'd1, 4'd2), '0, '0);
        run_instr(make_instr(OP_PASS_A, 1'b0, 4'd12, 4'd6, 4'd0), '0, '0);
        run_instr(make_instr(OP_XOR, 1'b0, PORT, 4'd0, 4'd0), '0, '0);  // A write port
        run_instr(make_instr(OP_AND, 1'b1, PORT, 4'd1, 4'd1), '0, '0);  // B write port
        run_instr(make_instr(OP_PASS_A, 1'b1, 4'd14, 4'd0, 4'd0), '0, '0);
    endtask

    task automatic stall_and_annul();
        run_instr(make_instr(OP_PASS_A, 1'b0, 4'd7, PORT, 4'd0), word_t'(rand_bits(WORD_W)), '0);
        a_io_in_empty = 1'b1;
        a_io_in       = ~mem_a[7];  // Differs from the word in A7
        expect_stall(make_instr(OP_PASS_A, 1'b0, 4'd7, PORT, 4'd0));
        run_instr(make_instr(OP_PASS_A, 1'b1, 4'd8, 4'd7, 4'd0), '0, '0);  // A7 unchanged
        a_io_in_empty = 1'b0;
        run_instr(make_instr(OP_PASS_A, 1'b0, 4'd7, PORT, 4'd0), word_t'(rand_bits(WORD_W)), '0);
        run_instr(make_instr(OP_PASS_A, 1'b1, 4'd8, 4'd7, 4'd0), '0, '0);

        a_io_out_full = 1'b1;
        expect_stall(make_instr(OP_ADD, 1'b0, PORT, 4'd0, 4'd0));
        a_io_out_full = 1'b0;
        run_instr(make_instr(OP_ADD, 1'b0, PORT, 4'd0, 4'd0), '0, '0);

        b_io_out_full = 1'b1;
        expect_stall(make_instr(OP_OR, 1'b1, PORT, 4'd1, 4'd2));
        b_io_out_full = 1'b0;
        run_instr(make_instr(OP_OR, 1'b1, PORT, 4'd1, 4'd2), '0, '0);

        b_io_in_empty = 1'b1;
        expect_stall(make_instr(OP_OR, 1'b1, 4'd9, 4'd4, PORT));
        b_io_in_empty = 1'b0;
    endtask

    task automatic back_to_back();
        instr_t seq [3];
        word_t  exp_r [3];
        int     k;
        seq[0] = make_instr(OP_ADD, 1'b0, 4'd13, 4'd0, 4'd1);
        seq[1] = make_instr(OP_XOR, 1'b1, 4'd13, 4'd2, 4'd3);
        seq[2] = make_instr(OP_OR, 1'b1, 4'd12, 4'd1, 4'd0);
        for (k = 0; k < 3; k++) begin
            exp_r[k] = expected_result(seq[k].op, mem_a[seq[k].a], mem_b[seq[k].b]);
        end
        for (k = 0; k < 5; k++) begin
            @(negedge clock);
            instr = (k < 3) ? seq[k] : '0;
            #1;
            if (k < 3) begin
                check("io_ready back to back", 32'(io_ready), 32'd1);
            end
            if (k >= 2) begin
                check("pipelined op", 32'(alu_result.op), 32'(seq[k-2].op));
                check("pipelined d", 32'(alu_result.d), 32'(seq[k-2].d));
                check("pipelined r", 32'(alu_result.r), 32'(exp_r[k-2]));
            end
        end
        mem_a[13] = exp_r[0];
        mem_b[13] = exp_r[1];
        mem_b[12] = exp_r[2];
    endtask

    initial begin
        clock         = 1'b0;
        rst_n         = 1'b0;
        instr         = make_instr(OP_PASS_A, 1'b0, PORT, 4'd0, 4'd0);  // Port write held in reset
        a_io_in_empty = 1'b0;
        b_io_in_empty = 1'b0;
        a_io_out_full = 1'b0;
        b_io_out_full = 1'b0;
        a_io_in       = '0;
        b_io_in       = '0;
        lfsr_state    = 32'd97599;

        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        instr = '0;

        check_reset_state();
        load_from_ports();
        alu_opcodes();
        write_back_routing();
        stall_and_annul();
        back_to_back();

        $display("All tests passed!");
        $finish;
    end

endmodule
